//--- common/midiLinkPkg.sv
// ==========================================================
// MIDI link shared definitions: clock and bit rate, baud
// accumulator increments, queue size and receive result type
// ==========================================================

package midiLinkPkg;

	// system clock and serial bit rate
	localparam int unsigned clkFreq = 250_000_000; // 4 ns clock
	localparam int unsigned baudRate = 31_250; // MIDI rate

	// fractional accumulator width, carry sits one bit above
	localparam int unsigned accWidth = 16;

	// one tick per bit, rounded to nearest
	localparam int unsigned txInc =
		((baudRate << (accWidth - 4)) + (clkFreq >> 5)) / (clkFreq >> 4);

	// sixteen ticks per bit for receive oversampling
	localparam int unsigned rxInc =
		(((baudRate * 16) << (accWidth - 4)) + (clkFreq >> 5)) / (clkFreq >> 4);

	// transmit queue holds 2**queueDepthLog2 bytes
	localparam int unsigned queueDepthLog2 = 3;

	// one received byte with its framing check
	typedef struct packed {
		logic [7:0] data; // LSB was first on the line
		logic frameErr; // stop bit sampled low
	} rxResultT;

endpackage

//--- src/baudTickGen.sv
// ==========================================================
// Baud tick generator: fractional phase accumulator whose
// carry gives one-cycle ticks, held clear while disabled
// ==========================================================

`timescale 1ns/1ns

module baudTickGen #(
	parameter int unsigned inc = 1 // added every enabled cycle
) (
	input logic clk,
	input logic rstN,
	input logic en,
	output logic tick
);

	// carry bit on top of the fraction
	logic [midiLinkPkg::accWidth:0] acc;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			acc <= '0;
		end else if (!en) begin
			acc <= '0; // restart phase so each frame starts aligned
		end else begin
			acc <= {1'b0, acc[midiLinkPkg::accWidth-1:0]}
				+ (midiLinkPkg::accWidth + 1)'(inc);
		end
	end

	// carry lasts one cycle since it is dropped on the next add
	assign tick = acc[midiLinkPkg::accWidth];

endmodule

//--- uartTx/txQueue.sv
// ==========================================================
// Transmit queue: small circular byte FIFO between the host
// write strobe and the serial transmitter
// ==========================================================

`timescale 1ns/1ns

module txQueue (
	input logic clk,
	input logic rstN,
	input logic push,
	input logic [7:0] pushData,
	input logic pop,
	output logic [7:0] headData,
	output logic notEmpty,
	output logic full
);

	logic [7:0] mem [0:(1 << midiLinkPkg::queueDepthLog2) - 1];
	logic [midiLinkPkg::queueDepthLog2-1:0] rdPtr;
	logic [midiLinkPkg::queueDepthLog2-1:0] wrPtr;
	logic [midiLinkPkg::queueDepthLog2:0] count; // one extra bit for the full case
	logic [midiLinkPkg::queueDepthLog2:0] nextCount;
	logic doPush;
	logic doPop;

	assign doPush = push && !full; // writes while full are lost
	assign doPop = pop && notEmpty;

	always_comb begin
		nextCount = count;
		if (doPush && !doPop) begin
			nextCount = count + 1'b1;
		end else if (doPop && !doPush) begin
			nextCount = count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			full <= 1'b0;
		end else begin
			if (doPush) wrPtr <= wrPtr + 1'b1; // wraps at depth
			if (doPop) rdPtr <= rdPtr + 1'b1;
			count <= nextCount;
			full <= nextCount[midiLinkPkg::queueDepthLog2]; // only set at exactly depth
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr] <= pushData;
	end

	assign headData = mem[rdPtr];
	assign notEmpty = (count != '0);

endmodule

//--- uartTx/serialTransmitter.sv
// ==========================================================
// Serial transmitter: 8N2 frame machine, LSB first, with a
// registered line output that stays glitch free
// ==========================================================

`timescale 1ns/1ns

module serialTransmitter (
	input logic clk,
	input logic rstN,
	input logic bitTick,
	input logic notEmpty,
	input logic [7:0] headData,
	output logic pop,
	output logic busy,
	output logic txd
);

	// data states carry the bit index in their low three bits
	typedef enum logic [3:0] {
		sIdle = 4'b0000,
		sWait = 4'b0001, // align to the first tick
		sStart = 4'b0100,
		sBit0 = 4'b1000,
		sBit1 = 4'b1001,
		sBit2 = 4'b1010,
		sBit3 = 4'b1011,
		sBit4 = 4'b1100,
		sBit5 = 4'b1101,
		sBit6 = 4'b1110,
		sBit7 = 4'b1111,
		sStop1 = 4'b0010,
		sStop2 = 4'b0011
	} txStateT;

	txStateT state;
	txStateT nextState;
	logic [7:0] dataReg;
	logic muxBit;

	assign pop = (state == sIdle) && notEmpty; // head taken at this edge
	assign busy = (state != sIdle);

	always_comb begin
		nextState = state;
		case (state)
			sIdle: if (notEmpty) nextState = sWait;
			sWait: if (bitTick) nextState = sStart;
			sStart: if (bitTick) nextState = sBit0;
			sBit0: if (bitTick) nextState = sBit1;
			sBit1: if (bitTick) nextState = sBit2;
			sBit2: if (bitTick) nextState = sBit3;
			sBit3: if (bitTick) nextState = sBit4;
			sBit4: if (bitTick) nextState = sBit5;
			sBit5: if (bitTick) nextState = sBit6;
			sBit6: if (bitTick) nextState = sBit7;
			sBit7: if (bitTick) nextState = sStop1;
			sStop1: if (bitTick) nextState = sStop2;
			sStop2: if (bitTick) nextState = sIdle;
			default: nextState = sIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= sIdle;
		end else begin
			state <= nextState;
		end
	end

	// byte is held for the whole frame
	always_ff @(posedge clk) begin
		if (pop) dataReg <= headData;
	end

	assign muxBit = dataReg[state[2:0]];

	// high for idle, wait and stops, low for start, data bit otherwise
	always_ff @(posedge clk) begin
		if (!rstN) begin
			txd <= 1'b1;
		end else begin
			txd <= (state < sStart) || (state[3] && muxBit);
		end
	end

endmodule

//--- uartRx/serialReceiver.sv
// ==========================================================
// Serial receiver: 16x oversampled 8N1-or-longer frames with
// start-bit recheck and a framing flag on each byte
// ==========================================================

`timescale 1ns/1ns

module serialReceiver (
	input logic clk,
	input logic rstN,
	input logic rxd,
	input logic sampleTick,
	output logic sampleEn,
	output logic rxValid,
	output midiLinkPkg::rxResultT rxResult
);

	typedef enum logic [2:0] {
		sIdle,
		sStart, // confirm the start bit at its middle
		sData,
		sStop,
		sWaitHigh // hold off until the line is back to mark
	} rxStateT;

	rxStateT state;
	logic [1:0] rxSync; // two-flop synchronizer
	logic rxPrev;
	logic rxS;
	logic fallEdge;
	logic [3:0] tickCnt;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic midBit; // 16th tick since the last sample point

	assign rxS = rxSync[1];
	assign fallEdge = rxPrev && !rxS;
	assign midBit = sampleTick && (tickCnt == 4'd15);

	// accumulator runs only while a frame is being sampled
	assign sampleEn = (state == sStart) || (state == sData) || (state == sStop);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rxSync <= 2'b11;
			rxPrev <= 1'b1;
		end else begin
			rxSync <= {rxSync[0], rxd};
			rxPrev <= rxS;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= sIdle;
			tickCnt <= '0;
			bitIdx <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			case (state)
				sIdle: begin
					tickCnt <= '0;
					bitIdx <= '0;
					if (fallEdge) state <= sStart;
				end
				sStart: begin
					if (sampleTick) begin
						tickCnt <= tickCnt + 1'b1;
						if (tickCnt == 4'd7) begin
							tickCnt <= '0; // next samples fall 16 ticks apart
							state <= rxS ? sIdle : sData; // high here means a glitch
						end
					end
				end
				sData: begin
					if (sampleTick) tickCnt <= tickCnt + 1'b1;
					if (midBit) begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7) state <= sStop;
					end
				end
				sStop: begin
					if (sampleTick) tickCnt <= tickCnt + 1'b1;
					if (midBit) begin
						rxValid <= 1'b1;
						state <= sWaitHigh;
					end
				end
				sWaitHigh: begin
					if (rxS) state <= sIdle;
				end
				default: state <= sIdle;
			endcase
		end
	end

	// payload shift and result capture
	always_ff @(posedge clk) begin
		if (state == sData && midBit) begin
			shiftReg <= {rxS, shiftReg[7:1]}; // LSB arrives first
		end
		if (state == sStop && midBit) begin
			rxResult.data <= shiftReg;
			rxResult.frameErr <= !rxS; // stop bit must be mark
		end
	end

endmodule

//--- src/midiLink.sv
// ==========================================================
// MIDI link top: host write queue, 8N2 transmitter and a
// 16x oversampling receiver, each with its own tick generator
// ==========================================================

`timescale 1ns/1ns

module midiLink (
	input logic clk,
	input logic rstN,
	input logic txStart,
	input logic [7:0] txData,
	input logic rxd,
	output logic txFull,
	output logic txBusy,
	output logic txd,
	output logic rxValid,
	output midiLinkPkg::rxResultT rxResult
);

	logic [7:0] headData;
	logic notEmpty;
	logic pop;
	logic bitTick;
	logic sampleEn;
	logic sampleTick;

	txQueue txQueue_i (
		.clk (clk),
		.rstN (rstN),
		.push (txStart),
		.pushData (txData),
		.pop (pop),
		.headData (headData),
		.notEmpty (notEmpty),
		.full (txFull)
	);

	serialTransmitter serialTransmitter_i (
		.clk (clk),
		.rstN (rstN),
		.bitTick (bitTick),
		.notEmpty (notEmpty),
		.headData (headData),
		.pop (pop),
		.busy (txBusy),
		.txd (txd)
	);

	// one tick per bit while a frame is going out
	baudTickGen #(.inc(midiLinkPkg::txInc)) txTick_i (
		.clk (clk),
		.rstN (rstN),
		.en (txBusy),
		.tick (bitTick)
	);

	// sixteen ticks per bit while the receiver samples
	baudTickGen #(.inc(midiLinkPkg::rxInc)) rxTick_i (
		.clk (clk),
		.rstN (rstN),
		.en (sampleEn),
		.tick (sampleTick)
	);

	serialReceiver serialReceiver_i (
		.clk (clk),
		.rstN (rstN),
		.rxd (rxd),
		.sampleTick (sampleTick),
		.sampleEn (sampleEn),
		.rxValid (rxValid),
		.rxResult (rxResult)
	);

endmodule

//--- tb/midiLinkTb.sv
// ==========================================================
// MIDI link testbench: loopback and driven-line tests with a
// byte scoreboard, a txd line decoder and a watchdog
// ==========================================================

`timescale 1ns/1ns

module midiLinkTb;

	// clocks per bit, from the accumulator increment
	localparam int bitCycles = int'((32'd1 << midiLinkPkg::accWidth) / midiLinkPkg::txInc);
	localparam int framesSent = 1 + 40 + 9 + 1 + 6 + 1; // tests 1 to 6
	localparam int watchdogCycles = framesSent * 11 * bitCycles * 2;
	localparam int queueDepth = 8;

	logic clk;
	logic rstN;
	logic txStart;
	logic [7:0] txData;
	logic rxd;
	logic txFull;
	logic txBusy;
	logic txd;
	logic rxValid;
	midiLinkPkg::rxResultT rxResult;

	logic loopback; // rxd follows txd when set
	logic tbLine; // serializer output
	logic [7:0] expData[$];
	logic expErr[$];
	int rxCount;
	int popCount; // frames started by the transmitter
	int errCount;
	int testErrs;
	int testsRun;
	int testsFailed;

	assign rxd = loopback ? txd : tbLine;

	midiLink dut_i (
		.clk (clk),
		.rstN (rstN),
		.txStart (txStart),
		.txData (txData),
		.rxd (rxd),
		.txFull (txFull),
		.txBusy (txBusy),
		.txd (txd),
		.rxValid (rxValid),
		.rxResult (rxResult)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			errCount++;
			testErrs++;
		end
	endtask

	task automatic reportFailure(input string msg);
		$display("%s at %0t", msg, $time);
		errCount++;
		testErrs++;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (testErrs != 0) testsFailed++;
		$display("test %0d %s: %s (%0d errors)", testsRun, name,
			(testErrs == 0) ? "ok" : "FAILED", testErrs);
		testErrs = 0;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic waitRx(input int n);
		while (rxCount < n) @(negedge clk);
	endtask

	task automatic waitIdle();
		while (txBusy) @(negedge clk);
	endtask

	task automatic expectByte(input logic [7:0] data, input logic stopLow);
		expData.push_back(data);
		expErr.push_back(stopLow);
	endtask

	task automatic writeByte(input logic [7:0] data);
		txData = data;
		txStart = 1'b1;
		@(negedge clk);
		txStart = 1'b0;
	endtask

	// scoreboard on rxValid and a count of frame starts
	task automatic watchLink();
		logic busyPrev;
		logic [7:0] wantData;
		logic wantErr;
		busyPrev = 1'b0;
		forever begin
			@(negedge clk);
			if (txBusy && !busyPrev) popCount++; // head left the queue
			busyPrev = txBusy;
			if (rxValid) begin
				if (expData.size() == 0) begin
					reportFailure("rxValid pulsed while no byte was expected");
				end else begin
					wantData = expData.pop_front();
					wantErr = expErr.pop_front();
					checkVal("rxResult.data", 32'(rxResult.data), 32'(wantData));
					checkVal("rxResult.frameErr", 32'(rxResult.frameErr), 32'(wantErr));
				end
				rxCount++;
			end
		end
	endtask

	// 8N2 frame on tbLine, start bit first
	task automatic sendFrame(input logic [7:0] data, input logic stopLow);
		logic [10:0] bits;
		bits = {1'b1, !stopLow, data, 1'b0};
		expectByte(data, stopLow);
		repeat (11) begin
			tbLine = bits[0];
			bits = bits >> 1;
			idleCycles(bitCycles);
		end
	endtask

	// decode txd at bit centers and check edges sit on bit boundaries
	task automatic decodeLine(input logic [7:0] written);
		logic [10:0] sampled;
		logic prevLevel;
		int offset;
		sampled = '0;
		while (txd) @(negedge clk); // start edge
		prevLevel = 1'b0;
		for (int c = 0; c < 11 * bitCycles; c++) begin
			if (txd !== prevLevel) begin
				offset = c % bitCycles;
				if (offset > 1 && offset < bitCycles - 1) begin
					reportFailure($sformatf("txd changed %0d clocks off a bit boundary", offset));
				end
				prevLevel = txd;
			end
			if (c % bitCycles == bitCycles / 2) sampled = {txd, sampled[10:1]};
			@(negedge clk);
		end
		checkVal("txd start bit", 32'(sampled[0]), 32'd0);
		checkVal("txd data byte", 32'(sampled[8:1]), 32'(written));
		checkVal("txd stop bits", 32'(sampled[10:9]), 32'd3);
	endtask

	initial begin
		logic [7:0] b;
		int base;
		int popBase;
		int pushCount;
		rstN = 1'b0;
		txStart = 1'b0;
		txData = 8'h00;
		loopback = 1'b1;
		tbLine = 1'b1;
		rxCount = 0;
		popCount = 0;
		errCount = 0;
		testErrs = 0;
		testsRun = 0;
		testsFailed = 0;
		void'($urandom(34));
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		fork
			watchLink();
		join_none

		// single byte through the loopback
		base = rxCount;
		b = 8'($urandom);
		expectByte(b, 1'b0);
		writeByte(b);
		@(negedge clk);
		checkVal("txBusy", 32'(txBusy), 32'd1);
		waitRx(base + 1);
		checkVal("txBusy", 32'(txBusy), 32'd1); // still in the stop bits
		waitIdle();
		checkVal("txd", 32'(txd), 32'd1);
		finishTest("single byte loopback");

		// random burst, gated by the model's queue occupancy
		base = rxCount;
		popBase = popCount;
		pushCount = 0;
		for (int i = 0; i < 40; i++) begin
			while (pushCount - (popCount - popBase) >= queueDepth) @(negedge clk);
			b = 8'($urandom);
			expectByte(b, 1'b0);
			writeByte(b);
			pushCount++;
			idleCycles($urandom_range(0, 20));
		end
		waitRx(base + 40);
		waitIdle();
		finishTest("random burst in order");

		// 12 strobes from idle: one taken, eight queued, three dropped
		base = rxCount;
		txStart = 1'b1;
		for (int i = 0; i < 12; i++) begin
			b = 8'($urandom);
			txData = b;
			if (i < 9) expectByte(b, 1'b0);
			@(negedge clk);
		end
		txStart = 1'b0;
		checkVal("txFull", 32'(txFull), 32'd1);
		waitRx(base + 9);
		waitIdle();
		idleCycles(16);
		checkVal("txBusy", 32'(txBusy), 32'd0);
		checkVal("rxCount", 32'(rxCount), 32'(base + 9));
		finishTest("overflow drop");

		// line format seen by an independent decoder
		base = rxCount;
		b = 8'($urandom);
		expectByte(b, 1'b0);
		writeByte(b);
		decodeLine(b);
		waitRx(base + 1);
		waitIdle();
		finishTest("line format");

		// driven frames, some with a low stop bit
		loopback = 1'b0;
		base = rxCount;
		for (int i = 0; i < 6; i++) begin
			sendFrame(8'($urandom), (i == 1) || ($urandom_range(0, 2) == 0));
			idleCycles(2 * bitCycles);
		end
		waitRx(base + 6);
		finishTest("framing error");

		// short low pulse, then a proper frame
		base = rxCount;
		tbLine = 1'b0;
		idleCycles($urandom_range(16, bitCycles * 7 / 16));
		tbLine = 1'b1;
		idleCycles(2 * bitCycles);
		checkVal("rxCount", 32'(rxCount), 32'(base));
		sendFrame(8'($urandom), 1'b0);
		idleCycles(2 * bitCycles);
		waitRx(base + 1);
		loopback = 1'b1;
		checkVal("pending expected bytes", 32'(expData.size()), 32'd0);
		finishTest("glitch rejection");

		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			testsRun, testsFailed, errCount);
		if (errCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// run length bound: every frame at eleven bits, doubled
	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: the tests did not finish within %0d clock cycles", watchdogCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- sources.f
common/midiLinkPkg.sv
src/baudTickGen.sv
uartTx/txQueue.sv
uartTx/serialTransmitter.sv
uartRx/serialReceiver.sv
src/midiLink.sv
tb/midiLinkTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the MIDI link testbench with Verilator, run it and check the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module midiLinkTb \
	-f sources.f \
	-Mdir obj_dir \
	-o midiLinkSim

./obj_dir/midiLinkSim | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
	exit 0
fi
echo "run.sh: no pass line found in sim.log" >&2
exit 1
